/* vlog.f */
source/la_pkg.sv
source/capture_mem_if.sv
source/sram_1r1w.sv
source/uart_transmit.sv
source/logic_analyzer.sv
source/la_top.sv
bench/la_assertions.sv
bench/la_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the logic analyzer testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module la_top_tb -o la_top_tb_sim

# The simulation result is judged from the log, not from the exit status
./obj_dir/la_top_tb_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log
then
    echo "Run passed"
    exit 0
else
    echo "Run failed, see sim.log"
    exit 1
fi

/* bench/la_top_tb.sv */
// Testbench for la_top that captures random samples, triggers, and decodes the serial dump.
// Each table row is one test, run after its own reset.
`timescale 1ns/10ps

module la_top_tb;
    localparam int WIDTH_BITS = 12;
    localparam int SIZE = 8;
    localparam int CLOCKS_PER_BIT = 4;
    localparam int BYTES_PER_SAMPLE = (WIDTH_BITS + 7) / 8;
    localparam int FRAME_CYCLES = 10 * CLOCKS_PER_BIT;
    localparam int NUM_TESTS = 5;

    typedef logic [WIDTH_BITS-1:0] sample_t;

    typedef struct packed
    {
        int captures;
        bit gaps;
        bit trigger_last;
        bit extra;
    } test_row_t;

    // Columns are captures, idle gaps in enable, trigger on last enable, activity after dump
    test_row_t tests [NUM_TESTS] = '{
        '{3, 1'b1, 1'b0, 1'b0},
        '{8, 1'b0, 1'b1, 1'b0},
        '{19, 1'b1, 1'b0, 1'b1},
        '{0, 1'b0, 1'b0, 1'b0},
        '{5, 1'b1, 1'b1, 1'b0}
    };

    logic clk;
    logic reset;
    sample_t capture_data;
    logic capture_enable;
    logic trigger;
    logic uart_tx;

    int seed = 3186;
    int error_count = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    // Last SIZE captured samples with the oldest at the front
    sample_t model [$];

    la_top #(
        .CAPTURE_WIDTH_BITS(WIDTH_BITS),
        .CAPTURE_SIZE(SIZE),
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .capture_data(capture_data),
        .capture_enable(capture_enable),
        .trigger(trigger),
        .uart_tx(uart_tx)
    );

    always #5 clk = ~clk;

    // Run limit guards against a dump that never ends
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Twice the serial time of every row plus a fixed margin per row
    function automatic int run_limit();
        int total;
        int entries;
        int r;
        total = 0;
        for (r = 0; r < NUM_TESTS; r++)
        begin
            entries = (tests[r].captures < SIZE) ? tests[r].captures : SIZE;
            total += entries * BYTES_PER_SAMPLE * 10 * CLOCKS_PER_BIT + 200;
        end
        return 2 * total;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] expected,
        input logic [15:0] actual);
        error_count++;
        $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string text);
        error_count++;
        $display("Failure at %0t: %s", $time, text);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        capture_enable = 1'b0;
        trigger = 1'b0;
        capture_data = '0;
        model.delete();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // Waits one clock and checks that the line is still idle
    task automatic step_idle_line();
        @(posedge clk);
        #1;
        if (uart_tx !== 1'b1)
            report_mismatch("uart_tx before trigger", 16'h1, 16'(uart_tx));
    endtask

    // Line must stay high for the given number of cycles
    task automatic watch_line_idle(input int cycles, input string where);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            #1;
            if (uart_tx !== 1'b1)
            begin
                report_mismatch({"uart_tx ", where}, 16'h1, 16'(uart_tx));
                break;
            end
        end
    endtask

    // Polls for a start bit, then samples every bit at its middle
    task automatic receive_frame(input int max_wait, output logic [7:0] value, output bit found);
        int waited;
        int b;
        waited = 0;
        found = 1'b0;
        value = '0;
        while (!found && waited < max_wait)
        begin
            @(posedge clk);
            #1;
            waited++;
            if (uart_tx === 1'b0)
                found = 1'b1;
        end
        if (found)
        begin
            repeat (CLOCKS_PER_BIT / 2) @(posedge clk);
            #1;
            if (uart_tx !== 1'b0)
                report_mismatch("uart_tx start bit", 16'h0, 16'(uart_tx));
            for (b = 0; b < 8; b++)
            begin
                repeat (CLOCKS_PER_BIT) @(posedge clk);
                #1;
                value[b] = uart_tx;
            end
            repeat (CLOCKS_PER_BIT) @(posedge clk);
            #1;
            if (uart_tx !== 1'b1)
                report_mismatch("uart_tx stop bit", 16'h1, 16'(uart_tx));
        end
    endtask

    task automatic run_test(input int index);
        test_row_t row;
        sample_t sample;
        logic [BYTES_PER_SAMPLE*8-1:0] padded;
        logic [7:0] expected_byte;
        logic [7:0] received;
        bit found;
        bit lost;
        int errors_before;
        int asserts_before;
        int byte_count;
        int i;
        int j;
        row = tests[index];
        errors_before = error_count;
        asserts_before = dut0.analyzer.analyzer_checks.failure_count;
        byte_count = 0;
        lost = 1'b0;
        reset_dut();

        // The model keeps what the capture buffer should hold
        for (i = 0; i < row.captures; i++)
        begin
            if (row.gaps && ($random(seed) & 1) != 0)
            begin
                capture_enable = 1'b0;
                step_idle_line();
            end
            sample = sample_t'($random(seed));
            capture_enable = 1'b1;
            capture_data = sample;
            trigger = row.trigger_last && i == row.captures - 1;
            model.push_back(sample);
            if (model.size() > SIZE)
                void'(model.pop_front());
            step_idle_line();
        end
        capture_enable = 1'b0;
        if (!(row.trigger_last && row.captures > 0))
        begin
            trigger = 1'b1;
            step_idle_line();
        end
        trigger = 1'b0;

        // Oldest sample first, low byte first, zero padding above the sample
        for (i = 0; i < model.size() && !lost; i++)
        begin
            padded = '0;
            padded[WIDTH_BITS-1:0] = model[i];
            for (j = 0; j < BYTES_PER_SAMPLE && !lost; j++)
            begin
                expected_byte = padded[j*8 +: 8];
                receive_frame(byte_count == 0 ? 3 : CLOCKS_PER_BIT / 2 + 2, received, found);
                if (!found)
                begin
                    report_failure($sformatf("no start bit in time for byte %0d", byte_count));
                    lost = 1'b1;
                end
                else if (received !== expected_byte)
                    report_mismatch($sformatf("uart_tx byte %0d", byte_count),
                        16'(expected_byte), 16'(received));
                byte_count++;
            end
        end

        if (!lost)
            watch_line_idle(2 * FRAME_CYCLES, "after the last frame");
        if (dut0.analyzer.state !== la_pkg::la_stopped)
            report_failure("controller did not stop after the dump");

        // Stopped analyzer must ignore new samples and a new trigger
        if (row.extra)
        begin
            for (i = 0; i < 6; i++)
            begin
                capture_enable = 1'b1;
                capture_data = sample_t'($random(seed));
                trigger = i == 5;
                @(posedge clk);
                #1;
            end
            capture_enable = 1'b0;
            trigger = 1'b0;
            watch_line_idle(20 * FRAME_CYCLES, "after a trigger while stopped");
        end

        if (error_count == errors_before
            && dut0.analyzer.analyzer_checks.failure_count == asserts_before)
            $display("Test %0d passed: %0d captures, %0d bytes checked",
                index + 1, row.captures, byte_count);
        else
        begin
            tests_failed++;
            $display("Test %0d failed: %0d captures, %0d errors, %0d assertion failures",
                index + 1, row.captures, error_count - errors_before,
                dut0.analyzer.analyzer_checks.failure_count - asserts_before);
        end
    endtask

    initial
    begin
        int t;
        clk = 1'b0;
        reset = 1'b1;
        capture_data = '0;
        capture_enable = 1'b0;
        trigger = 1'b0;
        cycle_limit = run_limit();
        for (t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
            NUM_TESTS, tests_failed, error_count,
            dut0.analyzer.analyzer_checks.failure_count);
        if (error_count == 0 && dut0.analyzer.analyzer_checks.failure_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* bench/la_assertions.sv */
// Concurrent protocol checks for the capture and dump controller.
// Bound into every logic_analyzer instance.
`timescale 1ns/10ps

module la_assertions
(
    input logic clk,
    input logic reset,
    input la_pkg::la_state_t state,
    input logic write_en,
    input logic tx_enable,
    input logic tx_ready
);
    // Running count of failed checks, read by the testbench at the end of a run
    int failure_count = 0;

    // A byte is only offered to an idle transmitter, which then leaves idle
    property enable_only_when_ready;
        @(posedge clk) disable iff (reset) tx_enable |=> $past(tx_ready) && !tx_ready;
    endproperty

    // The buffer is frozen from the start of the dump until the next reset
    property write_only_in_capture;
        @(posedge clk) disable iff (reset)
            state != la_pkg::la_capture
            |=> state != la_pkg::la_capture && !write_en && !$past(write_en);
    endproperty

    // Nothing is sent once the analyzer has stopped, and only reset leaves that state
    property quiet_when_stopped;
        @(posedge clk) disable iff (reset)
            state == la_pkg::la_stopped
            |=> state == la_pkg::la_stopped && !tx_enable && !$past(tx_enable);
    endproperty

    enable_ready_check: assert property (enable_only_when_ready)
        else
        begin
            failure_count++;
            $error("tx_enable high while tx_ready is low");
        end

    write_state_check: assert property (write_only_in_capture)
        else
        begin
            failure_count++;
            $error("capture buffer written outside the capture state");
        end

    stopped_check: assert property (quiet_when_stopped)
        else
        begin
            failure_count++;
            $error("tx_enable high in the stopped state");
        end

endmodule

bind logic_analyzer la_assertions analyzer_checks
(
    .clk(clk),
    .reset(reset),
    .state(state),
    .write_en(mem.write_en),
    .tx_enable(tx_enable),
    .tx_ready(tx_ready)
);

/* source/la_top.sv */
// Top level of the embedded logic analyzer.
// Connects the capture RAM, the controller and the serial transmitter.
`timescale 1ns/10ps

module la_top
#(
    parameter int CAPTURE_WIDTH_BITS = la_pkg::default_capture_width_bits,
    parameter int CAPTURE_SIZE = la_pkg::default_capture_size,
    parameter int CLOCKS_PER_BIT = la_pkg::default_clocks_per_bit
)
(
    input logic clk,
    input logic reset,
    input logic [CAPTURE_WIDTH_BITS-1:0] capture_data,
    input logic capture_enable,
    input logic trigger,
    output logic uart_tx
);
    // Controller to transmitter link
    la_pkg::uart_byte_t tx_char;
    logic tx_enable;
    logic tx_ready;

    capture_mem_if #(
        .CAPTURE_WIDTH_BITS(CAPTURE_WIDTH_BITS),
        .CAPTURE_SIZE(CAPTURE_SIZE)
    ) capture_mem ();

    sram_1r1w #(
        .CAPTURE_WIDTH_BITS(CAPTURE_WIDTH_BITS),
        .CAPTURE_SIZE(CAPTURE_SIZE)
    ) capture_ram (
        .clk(clk),
        .mem(capture_mem.memory)
    );

    logic_analyzer #(
        .CAPTURE_WIDTH_BITS(CAPTURE_WIDTH_BITS),
        .CAPTURE_SIZE(CAPTURE_SIZE)
    ) analyzer (
        .clk(clk),
        .reset(reset),
        .capture_data(capture_data),
        .capture_enable(capture_enable),
        .trigger(trigger),
        .mem(capture_mem.controller),
        .tx_char(tx_char),
        .tx_enable(tx_enable),
        .tx_ready(tx_ready)
    );

    uart_transmit #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) transmitter (
        .clk(clk),
        .reset(reset),
        .tx_enable(tx_enable),
        .tx_char(tx_char),
        .tx_ready(tx_ready),
        .uart_tx(uart_tx)
    );

endmodule

/* source/logic_analyzer.sv */
// Capture and dump controller of the logic analyzer.
// Samples go into a circular RAM until trigger, then are sent oldest first as bytes.
`timescale 1ns/10ps

module logic_analyzer
#(
    parameter int CAPTURE_WIDTH_BITS = la_pkg::default_capture_width_bits,
    parameter int CAPTURE_SIZE = la_pkg::default_capture_size
)
(
    input logic clk,
    input logic reset,
    input logic [CAPTURE_WIDTH_BITS-1:0] capture_data,
    input logic capture_enable,
    input logic trigger,
    capture_mem_if.controller mem,
    output la_pkg::uart_byte_t tx_char,
    output logic tx_enable,
    input logic tx_ready
);
    localparam int INDEX_WIDTH = $clog2(CAPTURE_SIZE);
    localparam int COUNT_WIDTH = $clog2(CAPTURE_SIZE + 1);
    localparam int CAPTURE_BYTES = (CAPTURE_WIDTH_BITS + 7) / 8;
    localparam int BYTE_INDEX_WIDTH = (CAPTURE_BYTES > 1) ? $clog2(CAPTURE_BYTES) : 1;

    typedef logic [INDEX_WIDTH-1:0] entry_index_t;
    typedef logic [COUNT_WIDTH-1:0] entry_count_t;
    typedef logic [BYTE_INDEX_WIDTH-1:0] byte_index_t;
    typedef logic [CAPTURE_BYTES*8-1:0] padded_word_t;

    la_pkg::la_state_t state;

    // Capture side
    entry_index_t capture_entry;
    entry_index_t capture_next;
    logic wrapped;
    logic wrapped_next;
    logic sample_write;

    // Dump side
    entry_index_t dump_entry;
    entry_count_t entries_left;
    byte_index_t dump_byte;
    logic data_valid;
    logic last_byte;
    padded_word_t padded_word;

    // A sample is stored on every enabled cycle in capture, the trigger cycle too
    assign sample_write = state == la_pkg::la_capture && capture_enable;

    // Pointer after this cycle's write, wraps on its own because the size is a power of two
    assign capture_next = sample_write ? capture_entry + 1'b1 : capture_entry;
    assign wrapped_next = wrapped
        || (sample_write && capture_entry == entry_index_t'(CAPTURE_SIZE - 1));

    assign mem.write_en = sample_write;
    assign mem.write_addr = capture_entry;
    assign mem.write_data = capture_data;

    // RAM output lags this address by one cycle, data_valid tracks that
    assign mem.read_addr = dump_entry;

    // Zero-pad the stored word at the top to whole bytes
    always_comb
    begin
        padded_word = '0;
        padded_word[CAPTURE_WIDTH_BITS-1:0] = mem.read_data;
    end

    // Low byte of each entry goes first
    assign tx_char = padded_word[dump_byte*8 +: 8];
    assign last_byte = dump_byte == byte_index_t'(CAPTURE_BYTES - 1);

    // Only offered while the transmitter is idle, so a high tx_enable is always accepted
    assign tx_enable = state == la_pkg::la_dump && data_valid && tx_ready;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= la_pkg::la_capture;
            capture_entry <= '0;
            wrapped <= 1'b0;
            dump_entry <= '0;
            entries_left <= '0;
            dump_byte <= '0;
            data_valid <= 1'b0;
        end
        else
        begin
            case (state)
                la_pkg::la_capture:
                begin
                    capture_entry <= capture_next;
                    wrapped <= wrapped_next;

                    if (trigger)
                    begin
                        state <= la_pkg::la_dump;
                        dump_byte <= '0;
                        data_valid <= 1'b0;

                        // Once full, the oldest entry is the one the pointer now names
                        if (wrapped_next)
                        begin
                            dump_entry <= capture_next;
                            entries_left <= entry_count_t'(CAPTURE_SIZE);
                        end
                        else
                        begin
                            dump_entry <= '0;
                            entries_left <= entry_count_t'(capture_next);
                        end
                    end
                end

                la_pkg::la_dump:
                begin
                    if (tx_enable)
                    begin
                        // Byte accepted by the transmitter this edge
                        if (last_byte)
                        begin
                            dump_byte <= '0;
                            dump_entry <= dump_entry + 1'b1;
                            entries_left <= entries_left - 1'b1;
                            data_valid <= 1'b0;
                            if (entries_left == entry_count_t'(1))
                                state <= la_pkg::la_stopped;
                        end
                        else
                        begin
                            dump_byte <= dump_byte + 1'b1;
                        end
                    end
                    else if (!data_valid)
                    begin
                        // Address was stable for a cycle, read data is now good
                        if (entries_left == '0)
                            state <= la_pkg::la_stopped;
                        else
                            data_valid <= 1'b1;
                    end
                end

                la_pkg::la_stopped:
                begin
                    // Stays here until reset
                    data_valid <= 1'b0;
                end

                default:
                    state <= la_pkg::la_stopped;
            endcase
        end
    end

endmodule

/* source/uart_transmit.sv */
// 8N1 serial transmitter used by the logic analyzer to dump its buffer.
// A byte is taken when tx_enable and tx_ready are high at the same edge.
`timescale 1ns/10ps

module uart_transmit
#(
    parameter int CLOCKS_PER_BIT = la_pkg::default_clocks_per_bit
)
(
    input logic clk,
    input logic reset,
    input logic tx_enable,
    input la_pkg::uart_byte_t tx_char,
    output logic tx_ready,
    output logic uart_tx
);
    localparam int PERIOD_WIDTH = $clog2(CLOCKS_PER_BIT + 1);

    typedef logic [PERIOD_WIDTH-1:0] bit_period_t;
    typedef logic [2:0] bit_index_t;

    la_pkg::uart_state_t state;
    bit_period_t period_count;
    bit_index_t bit_index;
    la_pkg::uart_byte_t shift_reg;
    logic bit_done;
    logic shift_now;

    // Ready only between frames
    assign tx_ready = state == la_pkg::tx_idle;

    // Counter runs from CLOCKS_PER_BIT down to 1, so each bit lasts exactly that long
    assign bit_done = period_count == bit_period_t'(1);

    // Next data bit goes out at the end of the start bit and of data bits 0 to 6
    assign shift_now = bit_done && (state == la_pkg::tx_start
        || (state == la_pkg::tx_data && bit_index != 3'd7));

    always_ff @(posedge clk)
    begin
        if (tx_ready && tx_enable)
            shift_reg <= tx_char;
        else if (shift_now)
            shift_reg <= {1'b0, shift_reg[7:1]};
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= la_pkg::tx_idle;
            period_count <= '0;
            bit_index <= '0;
            uart_tx <= 1'b1;
        end
        else
        begin
            if (period_count != '0)
                period_count <= period_count - 1'b1;

            case (state)
                la_pkg::tx_idle:
                begin
                    uart_tx <= 1'b1;
                    if (tx_enable)
                    begin
                        // Start bit begins on the next cycle
                        state <= la_pkg::tx_start;
                        period_count <= bit_period_t'(CLOCKS_PER_BIT);
                        uart_tx <= 1'b0;
                    end
                end

                la_pkg::tx_start:
                begin
                    if (bit_done)
                    begin
                        state <= la_pkg::tx_data;
                        period_count <= bit_period_t'(CLOCKS_PER_BIT);
                        bit_index <= '0;
                        uart_tx <= shift_reg[0];
                    end
                end

                la_pkg::tx_data:
                begin
                    if (bit_done)
                    begin
                        period_count <= bit_period_t'(CLOCKS_PER_BIT);
                        if (bit_index == 3'd7)
                        begin
                            state <= la_pkg::tx_stop;
                            uart_tx <= 1'b1;
                        end
                        else
                        begin
                            bit_index <= bit_index + 1'b1;
                            uart_tx <= shift_reg[0];
                        end
                    end
                end

                la_pkg::tx_stop:
                begin
                    // Line is already high, just wait out the stop bit
                    if (bit_done)
                        state <= la_pkg::tx_idle;
                end
            endcase
        end
    end

endmodule

/* source/sram_1r1w.sv */
// Dual-port synchronous RAM holding the circular capture buffer.
// One write port and one registered read port, both on clk.
`timescale 1ns/10ps

module sram_1r1w
#(
    parameter int CAPTURE_WIDTH_BITS = la_pkg::default_capture_width_bits,
    parameter int CAPTURE_SIZE = la_pkg::default_capture_size
)
(
    input logic clk,
    capture_mem_if.memory mem
);
    typedef logic [CAPTURE_WIDTH_BITS-1:0] sample_t;

    // Storage array, contents are undefined until written
    sample_t data [CAPTURE_SIZE];

    always_ff @(posedge clk)
    begin
        if (mem.write_en)
            data[mem.write_addr] <= mem.write_data;

        // Registered read, a same-cycle write to this address shows up next time
        mem.read_data <= data[mem.read_addr];
    end

endmodule

/* source/capture_mem_if.sv */
// Write and read ports of the capture buffer RAM.
// The controller owns the addresses and write data, the memory returns read data.
`timescale 1ns/10ps

interface capture_mem_if
#(
    parameter int CAPTURE_WIDTH_BITS = la_pkg::default_capture_width_bits,
    parameter int CAPTURE_SIZE = la_pkg::default_capture_size
);
    localparam int INDEX_WIDTH = $clog2(CAPTURE_SIZE);

    // Write side, sampled at the clock edge
    logic write_en;
    logic [INDEX_WIDTH-1:0] write_addr;
    logic [CAPTURE_WIDTH_BITS-1:0] write_data;

    // Read side, data follows the address by one cycle
    logic [INDEX_WIDTH-1:0] read_addr;
    logic [CAPTURE_WIDTH_BITS-1:0] read_data;

    modport controller
    (
        output write_en, write_addr, write_data, read_addr,
        input read_data
    );

    modport memory
    (
        input write_en, write_addr, write_data, read_addr,
        output read_data
    );

endinterface

/* source/la_pkg.sv */
// Shared types and default parameter values for the embedded logic analyzer.
// Modules refer to these by scoped name, la_pkg::name.
package la_pkg;

    // One character on the serial line
    typedef logic [7:0] uart_byte_t;

    // Capture and dump controller states
    typedef enum logic [1:0]
    {
        la_capture,
        la_dump,
        la_stopped
    } la_state_t;

    // Serial transmitter states, one per part of an 8N1 frame
    typedef enum logic [1:0]
    {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_state_t;

    // Top-level defaults
    parameter int default_capture_width_bits = 32;
    parameter int default_capture_size = 64;

    // 50 MHz system clock divided down to 921600 baud
    parameter int default_clocks_per_bit = 54;

endpackage
